// File: common/encoder_pkg.sv
`default_nettype none

package encoder_pkg;

    localparam int char_w = 8;

    // defaults that encoder_top hands down to the submodules
    localparam int text_aw_default  = 6;
    localparam int word_len_default = 4;
    localparam int vocab_n_default  = 8;

    typedef enum logic [2:0] {
        ENC_IDLE,
        ENC_START_WORD,
        ENC_WAIT_MATCH,
        ENC_WRITE,
        ENC_DONE
    } enc_state_e;

    typedef enum logic [2:0] {
        M_IDLE,
        M_READ,        // addresses go to both RAMs
        M_COMPARE,     // read data is back
        M_NEXT_ENTRY,
        M_REPORT
    } match_state_e;

    // target of a host write
    typedef enum logic {
        MEM_TEXT,
        MEM_VOCAB
    } mem_sel_e;

endpackage

`default_nettype wire

// File: common/match_if.sv
`default_nettype none

interface match_if #(
    parameter int TEXT_AW = encoder_pkg::text_aw_default,
    parameter int VOCAB_N = encoder_pkg::vocab_n_default
);
    localparam int TOK_W = $clog2(VOCAB_N + 1);

    logic               start;
    logic [TEXT_AW-1:0] word_addr;   // first character of the current word
    logic               done;
    logic               found;
    logic [TOK_W-1:0]   token;
    logic [TEXT_AW-1:0] word_len;
    logic               empty;

    // word_addr is driven by the cursor and passes the controller side on its way in
    modport ctrl (
        output start,
        input  word_addr,
        input  done,
        input  found,
        input  token,
        input  empty
    );

    modport match (
        input  start,
        input  word_addr,
        output done,
        output found,
        output token,
        output word_len,
        output empty
    );

endinterface

`default_nettype wire

// File: encoder/encoder_ctrl.sv
`default_nettype none

module encoder_ctrl #(
    parameter int TEXT_AW = encoder_pkg::text_aw_default,
    parameter int VOCAB_N = encoder_pkg::vocab_n_default,
    localparam int TOK_W  = $clog2(VOCAB_N + 1)
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_req,
    output logic               start_ack,
    output logic               busy,
    output logic [TEXT_AW-1:0] token_count,
    match_if.ctrl              m,
    output logic               adv_word,
    output logic               out_we,
    output logic [TOK_W-1:0]   out_wdata
);
    import encoder_pkg::*;

    enc_state_e         state;
    logic [TEXT_AW-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENC_IDLE;
            count <= '0;
        end else begin
            case (state)
                ENC_IDLE: begin
                    if (start_req) begin
                        count <= '0;
                        state <= ENC_START_WORD;
                    end
                end
                ENC_START_WORD: begin
                    // the matcher has to close the previous handshake first
                    if (!m.done) begin
                        state <= ENC_WAIT_MATCH;
                    end
                end
                ENC_WAIT_MATCH: begin
                    if (m.done) begin
                        state <= m.empty ? ENC_DONE : ENC_WRITE;   // empty word ends the text
                    end
                end
                ENC_WRITE: begin
                    count <= count + 1'b1;
                    state <= ENC_START_WORD;
                end
                ENC_DONE: begin
                    if (!start_req) begin
                        state <= ENC_IDLE;
                    end
                end
                default: state <= ENC_IDLE;
            endcase
        end
    end

    // start stays up until done is seen, then drops with the state change
    assign m.start = (state == ENC_WAIT_MATCH);

    assign busy      = (state != ENC_IDLE);
    assign start_ack = (state == ENC_DONE);

    // matcher still holds its result during the write cycle
    assign out_we    = (state == ENC_WRITE);
    assign adv_word  = (state == ENC_WRITE);
    assign out_wdata = m.found ? m.token : '0;

    assign token_count = count;

endmodule

`default_nettype wire

// File: encoder/matcher.sv
`default_nettype none

module matcher #(
    parameter int TEXT_AW   = encoder_pkg::text_aw_default,
    parameter int WORD_LEN  = encoder_pkg::word_len_default,
    parameter int VOCAB_N   = encoder_pkg::vocab_n_default,
    localparam int VOCAB_AW = $clog2(VOCAB_N * WORD_LEN),
    localparam int TOK_W    = $clog2(VOCAB_N + 1)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    match_if.match                        m,
    output logic [TEXT_AW-1:0]            text_raddr,
    input  logic [encoder_pkg::char_w-1:0] text_rdata,
    output logic [VOCAB_AW-1:0]           vocab_raddr,
    input  logic [encoder_pkg::char_w-1:0] vocab_rdata
);
    import encoder_pkg::*;

    match_state_e       state;
    logic [TOK_W-1:0]   entry;
    logic [TEXT_AW-1:0] pos;
    logic               len_known;
    logic [TEXT_AW-1:0] len_r;
    logic               found_r;
    logic               empty_r;
    logic [TOK_W-1:0]   token_r;
    logic [char_w-1:0]  vchar;
    logic               scan;

    // once every entry has failed before the terminator was seen, the entry counter
    // sits at VOCAB_N and the text alone is walked to find the word length
    assign scan = (entry == TOK_W'(VOCAB_N));

    assign text_raddr  = m.word_addr + pos;
    assign vocab_raddr = VOCAB_AW'(entry * WORD_LEN + pos);

    // one position past the entry reads as padding, so a full-length word needs its zero there
    assign vchar = (pos == TEXT_AW'(WORD_LEN)) ? '0 : vocab_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= M_IDLE;
            entry     <= '0;
            pos       <= '0;
            len_known <= 1'b0;
            len_r     <= '0;
            found_r   <= 1'b0;
            empty_r   <= 1'b0;
            token_r   <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (m.start) begin
                        entry     <= '0;
                        pos       <= '0;
                        len_known <= 1'b0;
                        found_r   <= 1'b0;
                        empty_r   <= 1'b0;
                        token_r   <= '0;
                        state     <= M_READ;
                    end
                end
                M_READ: state <= M_COMPARE;
                M_COMPARE: begin
                    if (text_rdata == '0 && !len_known) begin
                        len_known <= 1'b1;
                        len_r     <= pos;
                    end
                    if (scan) begin
                        if (text_rdata == '0) begin
                            state <= M_REPORT;
                        end else begin
                            pos   <= pos + 1'b1;
                            state <= M_READ;
                        end
                    end else if (text_rdata == '0 && pos == '0) begin
                        empty_r <= 1'b1;   // seen on the first entry already
                        state   <= M_REPORT;
                    end else if (text_rdata != vchar) begin
                        state <= M_NEXT_ENTRY;
                    end else if (text_rdata == '0) begin
                        found_r <= 1'b1;
                        token_r <= entry + TOK_W'(1);
                        state   <= M_REPORT;
                    end else begin
                        pos   <= pos + 1'b1;
                        state <= M_READ;
                    end
                end
                M_NEXT_ENTRY: begin
                    pos   <= '0;
                    entry <= entry + TOK_W'(1);
                    if (entry == TOK_W'(VOCAB_N - 1) && len_known) begin
                        state <= M_REPORT;
                    end else begin
                        state <= M_READ;
                    end
                end
                M_REPORT: begin
                    if (!m.start) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    assign m.done     = (state == M_REPORT);
    assign m.found    = found_r;
    assign m.token    = token_r;
    assign m.word_len = len_r;
    assign m.empty    = empty_r;

endmodule

`default_nettype wire

// File: encoder/text_cursor.sv
`default_nettype none

module text_cursor #(
    parameter int TEXT_AW = encoder_pkg::text_aw_default
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               adv_word,
    input  logic [TEXT_AW-1:0] word_len,
    output logic [TEXT_AW-1:0] word_addr,
    output logic [TEXT_AW-1:0] out_index
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_addr <= '0;
            out_index <= '0;
        end else if (clear) begin
            word_addr <= '0;
            out_index <= '0;
        end else if (adv_word) begin
            word_addr <= word_addr + word_len + 1'b1;   // step over the terminating zero
            out_index <= out_index + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/encoder_top.sv
`default_nettype none

module encoder_top #(
    parameter int TEXT_AW   = encoder_pkg::text_aw_default,
    parameter int WORD_LEN  = encoder_pkg::word_len_default,
    parameter int VOCAB_N   = encoder_pkg::vocab_n_default,
    localparam int VOCAB_AW = $clog2(VOCAB_N * WORD_LEN),
    localparam int TOK_W    = $clog2(VOCAB_N + 1),
    localparam int HOST_AW  = (TEXT_AW > VOCAB_AW) ? TEXT_AW : VOCAB_AW
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          host_we,
    input  encoder_pkg::mem_sel_e         host_sel,
    input  logic [HOST_AW-1:0]            host_addr,
    input  logic [encoder_pkg::char_w-1:0] host_wdata,
    input  logic                          start_req,
    output logic                          start_ack,
    input  logic [TEXT_AW-1:0]            out_addr,
    output logic [TOK_W-1:0]              out_token,
    output logic [TEXT_AW-1:0]            token_count,
    output logic                          busy
);
    import encoder_pkg::*;

    logic                host_ok;
    logic                text_we;
    logic                vocab_we;
    logic [TEXT_AW-1:0]  text_raddr;
    logic [char_w-1:0]   text_rdata;
    logic [VOCAB_AW-1:0] vocab_raddr;
    logic [char_w-1:0]   vocab_rdata;
    logic                adv_word;
    logic                out_we;
    logic [TOK_W-1:0]    out_wdata;
    logic [TEXT_AW-1:0]  out_index;

    match_if #(
        .TEXT_AW(TEXT_AW),
        .VOCAB_N(VOCAB_N)
    ) m_if ();

    // the host cannot touch the memories while a run is in progress
    assign host_ok  = host_we && !busy;
    assign text_we  = host_ok && (host_sel == MEM_TEXT);
    assign vocab_we = host_ok && (host_sel == MEM_VOCAB);

    sram #(
        .AW(TEXT_AW),
        .DW(char_w)
    ) text_ram (
        .clk  (clk),
        .we   (text_we),
        .waddr(host_addr[TEXT_AW-1:0]),
        .wdata(host_wdata),
        .raddr(text_raddr),
        .rdata(text_rdata)
    );

    // entry e, character c lives at e * WORD_LEN + c
    sram #(
        .AW(VOCAB_AW),
        .DW(char_w)
    ) vocab_ram (
        .clk  (clk),
        .we   (vocab_we),
        .waddr(host_addr[VOCAB_AW-1:0]),
        .wdata(host_wdata),
        .raddr(vocab_raddr),
        .rdata(vocab_rdata)
    );

    sram #(
        .AW(TEXT_AW),
        .DW(TOK_W)
    ) out_ram (
        .clk  (clk),
        .we   (out_we),
        .waddr(out_index),
        .wdata(out_wdata),
        .raddr(out_addr),
        .rdata(out_token)
    );

    encoder_ctrl #(
        .TEXT_AW(TEXT_AW),
        .VOCAB_N(VOCAB_N)
    ) i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_req  (start_req),
        .start_ack  (start_ack),
        .busy       (busy),
        .token_count(token_count),
        .m          (m_if.ctrl),
        .adv_word   (adv_word),
        .out_we     (out_we),
        .out_wdata  (out_wdata)
    );

    // cursor rewinds while a finished run is acknowledged, so every run starts at zero
    text_cursor #(
        .TEXT_AW(TEXT_AW)
    ) i_cursor (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (start_ack),
        .adv_word (adv_word),
        .word_len (m_if.word_len),
        .word_addr(m_if.word_addr),
        .out_index(out_index)
    );

    matcher #(
        .TEXT_AW (TEXT_AW),
        .WORD_LEN(WORD_LEN),
        .VOCAB_N (VOCAB_N)
    ) i_matcher (
        .clk        (clk),
        .rst_n      (rst_n),
        .m          (m_if.match),
        .text_raddr (text_raddr),
        .text_rdata (text_rdata),
        .vocab_raddr(vocab_raddr),
        .vocab_rdata(vocab_rdata)
    );

endmodule

`default_nettype wire

// File: hw/sram.sv
`default_nettype none

module sram #(
    parameter int AW = 6,
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [DW-1:0] wdata,
    input  logic [AW-1:0] raddr,
    output logic [DW-1:0] rdata
);

    logic [DW-1:0] mem [2**AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];   // same-address access returns the old word
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps --top-module tb_encoder -f tb.f \
    -o sim_encoder > build.log 2>&1 \
    && ./obj_dir/sim_encoder > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

grep -q "TEST PASS" sim.log && echo "simulation passed" \
    || { tail -n 20 sim.log; echo "simulation failed"; exit 1; }

// File: tb.f
common/encoder_pkg.sv
common/match_if.sv
hw/sram.sv
encoder/encoder_ctrl.sv
encoder/text_cursor.sv
encoder/matcher.sv
hw/encoder_top.sv
verification/encoder_checker.sv
verification/tb_encoder.sv

// File: verification/encoder_checker.sv
`default_nettype none

module encoder_checker #(
    parameter int TEXT_AW = encoder_pkg::text_aw_default,
    parameter int TOK_W   = 4
) (
    input logic               clk,
    input logic               rst_n,
    input logic               start_req,
    input logic               start_ack,
    input logic               busy,
    input logic [TEXT_AW-1:0] token_count,
    input logic [TOK_W-1:0]   out_token
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned error_count    = 0;
    int unsigned test_errors    = 0;
    int unsigned test_num       = 0;
    int unsigned tests_passed   = 0;
    int unsigned tests_failed   = 0;
    logic        ack_q          = 1'b0;
    int unsigned ack_low_cycles = 0;   // cycles with start_ack high after start_req fell

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic flag_error(input string msg);
        $display("Error at %0.1f ns: %s", $realtime, msg);
        count_error();
    endtask

    task automatic begin_test(input int unsigned num);
        test_num    = num;
        test_errors = 0;
    endtask

    task automatic check_count(input int unsigned expected);
        if (token_count !== TEXT_AW'(expected)) begin
            $display("Fail at %0.1f ns: token_count expected %0d, got %0d",
                     $realtime, expected, token_count);
            count_error();
        end
    endtask

    // out_token is already valid for idx when this is called
    task automatic check_token(input int unsigned idx, input logic [TOK_W-1:0] expected);
        if (out_token !== expected) begin
            $display("Fail at %0.1f ns: out_token[%0d] expected %0d, got %0d",
                     $realtime, idx, expected, out_token);
            count_error();
        end
    endtask

    task automatic end_test(input int unsigned n_tokens);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d: %0d tokens as expected", test_num, n_tokens);
        end else begin
            tests_failed++;
            $display("test %0d: %0d errors", test_num, test_errors);
        end
    endtask

    task automatic report_counts();
        $display("tests run %0d: %0d passed, %0d failed, %0d errors in total",
                 test_num, tests_passed, tests_failed, error_count);
    endtask

    // the start handshake, sampled on the clock edge before the DUT updates
    always @(posedge clk) begin
        if (!rst_n) begin
            if (busy || start_ack) begin
                flag_error("busy or start_ack is high during reset");
            end
            ack_q          <= 1'b0;
            ack_low_cycles <= 0;
        end else begin
            if (start_ack && !ack_q && !start_req) begin
                flag_error("start_ack rose without start_req");
            end
            if (ack_q && !start_ack && start_req) begin
                flag_error("start_ack fell while start_req was still high");
            end
            if (start_ack && !start_req) begin
                if (ack_low_cycles >= 2) begin
                    flag_error("start_ack still high two cycles after start_req fell");
                end
                ack_low_cycles <= ack_low_cycles + 1;
            end else begin
                ack_low_cycles <= 0;
            end
            ack_q <= start_ack;
        end
    end

endmodule

`default_nettype wire

// File: verification/encoder_vectors.txt
// record kinds: 01 vocabulary load, 02 test, ff end of file
// 01 then 8 entries of 4 characters, zero padded
// 02 flags text_len text[text_len] token_count tokens[token_count]
// flags bit 0 loads the text, bit 1 adds host writes while busy
// vocabulary: cat dog a tree run sun big hous
01
63 61 74 00  64 6f 67 00  61 00 00 00  74 72 65 65
72 75 6e 00  73 75 6e 00  62 69 67 00  68 6f 75 73
// cat a tree dog
02 01 10
63 61 74 00 61 00 74 72 65 65 00 64 6f 67 00 00
04 01 03 04 02
// ca house fox sun, prefix and longer words are unknown
02 01 12
63 61 00 68 6f 75 73 65 00 66 6f 78 00 73 75 6e 00 00
04 00 00 00 06
// text that starts with an empty word
02 01 01 00 00
// big run a, with text writes during the run, then a rerun without reload
02 03 0b 62 69 67 00 72 75 6e 00 61 00 00 03 07 05 03
02 00 00 03 07 05 03
// new vocabulary: run big fox a dog cat sun tree
01
72 75 6e 00  62 69 67 00  66 6f 78 00  61 00 00 00
64 6f 67 00  63 61 74 00  73 75 6e 00  74 72 65 65
// big run a fox
02 01 0f 62 69 67 00 72 75 6e 00 61 00 66 6f 78 00 00
04 02 01 04 03
ff

// File: verification/tb_encoder.sv
`default_nettype none

module tb_encoder;
    timeunit 1ns;
    timeprecision 100ps;
    import encoder_pkg::*;

    localparam int TEXT_AW  = text_aw_default;
    localparam int WORD_LEN = word_len_default;
    localparam int VOCAB_N  = vocab_n_default;
    localparam int TOK_W    = $clog2(VOCAB_N + 1);
    localparam int VOCAB_AW = $clog2(VOCAB_N * WORD_LEN);
    localparam int HOST_AW  = (TEXT_AW > VOCAB_AW) ? TEXT_AW : VOCAB_AW;
    localparam int VEC_N    = 512;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               host_we;
    mem_sel_e           host_sel;
    logic [HOST_AW-1:0] host_addr;
    logic [char_w-1:0]  host_wdata;
    logic               start_req;
    logic               start_ack;
    logic [TEXT_AW-1:0] out_addr;
    logic [TOK_W-1:0]   out_token;
    logic [TEXT_AW-1:0] token_count;
    logic               busy;

    logic [7:0]  vec [VEC_N];
    int unsigned limit_cycles = 0;

    always #2 clk = ~clk;

    encoder_top #(
        .TEXT_AW (TEXT_AW),
        .WORD_LEN(WORD_LEN),
        .VOCAB_N (VOCAB_N)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_we    (host_we),
        .host_sel   (host_sel),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .start_req  (start_req),
        .start_ack  (start_ack),
        .out_addr   (out_addr),
        .out_token  (out_token),
        .token_count(token_count),
        .busy       (busy)
    );

    encoder_checker #(
        .TEXT_AW(TEXT_AW),
        .TOK_W  (TOK_W)
    ) i_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_req  (start_req),
        .start_ack  (start_ack),
        .busy       (busy),
        .token_count(token_count),
        .out_token  (out_token)
    );

    // worst case per word is every entry compared to its padding plus a full text scan
    function automatic int unsigned budget_cycles();
        int unsigned p;
        int unsigned n;
        int unsigned k;
        int unsigned cycles;
        p      = 0;
        cycles = 100;
        while (p < VEC_N && vec[p] != 8'hff) begin
            if (vec[p] == 8'h01) begin
                cycles += VOCAB_N * WORD_LEN + 4;
                p      += 1 + VOCAB_N * WORD_LEN;
            end else begin
                n = 32'(vec[p + 2]);
                k = 32'(vec[p + 3 + n]);
                cycles += n + 2 * k + 20
                        + (k + 1) * (VOCAB_N * (2 * WORD_LEN + 3) + 2 * (2 ** TEXT_AW));
                p += 4 + n + k;
            end
        end
        return cycles;
    endfunction

    task automatic host_write(input mem_sel_e sel, input int unsigned addr,
                              input logic [7:0] data);
        @(posedge clk);
        #0.5;
        host_we    = 1'b1;
        host_sel   = sel;
        host_addr  = HOST_AW'(addr);
        host_wdata = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        #0.5;
        host_we = 1'b0;
    endtask

    task automatic run_encoder(input logic junk, input int unsigned n_tokens);
        int unsigned j;
        j = 0;
        @(posedge clk);
        #0.5;
        start_req = 1'b1;
        while (!start_ack) begin
            @(posedge clk);
            #0.5;
            host_we    = junk;   // these must all be dropped
            host_sel   = MEM_TEXT;
            host_addr  = HOST_AW'(j);
            host_wdata = 8'h7a;
            j++;
        end
        host_we = 1'b0;
        i_chk.check_count(n_tokens);
        @(posedge clk);
        #0.5;
        start_req = 1'b0;
        while (start_ack) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic read_token(input int unsigned idx, input logic [7:0] expected);
        @(posedge clk);
        #0.5;
        out_addr = TEXT_AW'(idx);
        @(posedge clk);
        #0.5;
        i_chk.check_token(idx, expected[TOK_W-1:0]);
    endtask

    initial begin
        int unsigned p;
        int unsigned n;
        int unsigned k;
        int unsigned i;
        int unsigned test_num;
        logic [7:0]  flags;
        rst_n      = 1'b0;
        host_we    = 1'b0;
        host_sel   = MEM_TEXT;
        host_addr  = '0;
        host_wdata = '0;
        start_req  = 1'b0;
        out_addr   = '0;
        for (i = 0; i < VEC_N; i++) begin
            vec[i] = 8'hff;   // unread entries act as the end marker
        end
        $readmemh("verification/encoder_vectors.txt", vec);
        limit_cycles = budget_cycles();
        repeat (3) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        p        = 0;
        test_num = 0;
        while (p < VEC_N && vec[p] != 8'hff) begin
            if (vec[p] == 8'h01) begin
                for (i = 0; i < VOCAB_N * WORD_LEN; i++) begin
                    host_write(MEM_VOCAB, i, vec[p + 1 + i]);
                end
                end_writes();
                p += 1 + VOCAB_N * WORD_LEN;
            end else if (vec[p] == 8'h02) begin
                flags = vec[p + 1];
                n     = 32'(vec[p + 2]);
                k     = 32'(vec[p + 3 + n]);
                test_num++;
                i_chk.begin_test(test_num);
                if (flags[0]) begin
                    for (i = 0; i < n; i++) begin
                        host_write(MEM_TEXT, i, vec[p + 3 + i]);
                    end
                    end_writes();
                end
                run_encoder(flags[1], k);
                for (i = 0; i < k; i++) begin
                    read_token(i, vec[p + 4 + n + i]);
                end
                i_chk.end_test(k);
                p += 4 + n + k;
            end else begin
                i_chk.flag_error("vector file holds a record of unknown kind");
                p = VEC_N;
            end
        end
        if (test_num == 0) begin
            i_chk.flag_error("vector file holds no tests");
        end

        i_chk.report_counts();
        if (i_chk.error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
